// ==== sim/debug_stim.txt ====
# cmd value expected
# L word expected_address, M/X mode byte {o_start,o_run}, S/F base word {o_start,o_run}
L 00000013 0
L 00a00093 1
L 00208133 2
L 00000000 0
X 5a 0
M ff 2
S 12340000 2
S 56780000 2
F 0bad0000 0
L 00100073 0
L 00000000 0
M 00 3
F 7e570000 0
L 00300193 0

// ==== src.f ====
hw/debug_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/program_loader.sv
hw/dump_serializer.sv
hw/debug_control.sv
hw/debug_unit.sv
sim/tb_debug_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f src.f --top-module tb_debug_unit
./obj_dir/Vtb_debug_unit | tee sim.log
if grep -q '\*\* PASS \*\*' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== sim/tb_debug_unit.sv ====
module tb_debug_unit import debug_pkg::*; ();

    logic                  i_clock;
    logic                  i_reset;
    logic                  i_rx;
    logic                  i_finish;
    logic [WORD_WIDTH-1:0] i_pc;
    logic [WORD_WIDTH-1:0] i_reg;
    logic [WORD_WIDTH-1:0] i_mem;
    logic                  o_tx;
    logic [WORD_WIDTH-1:0] o_instruction;
    logic [WORD_WIDTH-1:0] o_address;
    logic                  o_loading;
    logic                  o_start;
    logic                  o_step;
    logic                  o_run;
    logic                  o_reg_send;
    logic                  o_mem_send;

    logic [WORD_WIDTH-1:0] base;
    int                    reg_index;
    int                    mem_index;
    int                    step_count;
    int                    cycle_count;
    int                    cycle_limit;
    logic [WORD_WIDTH-1:0] load_instr_q[$];
    logic [WORD_WIDTH-1:0] load_addr_q[$];
    logic [BYTE_WIDTH-1:0] tx_q[$];
    logic [BYTE_WIDTH-1:0] cmd_q[$];
    logic [WORD_WIDTH-1:0] value_q[$];
    logic [WORD_WIDTH-1:0] expected_q[$];

    debug_unit i_debug_unit (.*);

    initial begin
        i_clock = 1'b0;
        forever #4 i_clock = ~i_clock;
    end

    task automatic stop_run();
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_value_error(input string name, input logic [31:0] got,
                                      input logic [31:0] want);
        $display("ERROR %s got 0x%h expected 0x%h", name, got, want);
        stop_run();
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        stop_run();
    endtask

    // Drives one 8N1 frame starting and ending just after a rising edge
    task automatic send_byte(input logic [BYTE_WIDTH-1:0] data);
        logic [BYTE_WIDTH+1:0] frame;
        int                    i;
        frame = {1'b1, data, 1'b0};
        for (i = 0; i < BYTE_WIDTH + 2; i++) begin
            i_rx = frame[i];
            repeat (BIT_CLOCKS) @(posedge i_clock);
            #1;
        end
    endtask

    // PC, then registers, then memory, each word LSB first
    task automatic check_dump(input logic [WORD_WIDTH-1:0] dump_base);
        logic [WORD_WIDTH-1:0] want;
        logic [BYTE_WIDTH-1:0] got;
        int                    w;
        int                    b;
        while (tx_q.size() < BYTES_PER_WORD * (1 + DUMP_REGS + DUMP_MEMS)) begin
            @(negedge i_clock);
        end
        for (w = 0; w < 1 + DUMP_REGS + DUMP_MEMS; w++) begin
            if (w == 0) begin
                want = dump_base;
            end else if (w <= DUMP_REGS) begin
                want = dump_base + w - 1;
            end else begin
                want = dump_base + 32'h1000 + w - 1 - DUMP_REGS;
            end
            for (b = 0; b < BYTES_PER_WORD; b++) begin
                got = tx_q.pop_front();
                assert (got == want[8*b +: 8])
                    else report_value_error("o_tx byte", {24'd0, got}, {24'd0, want[8*b +: 8]});
            end
        end
        assert (reg_index == DUMP_REGS)
            else report_value_error("o_reg_send count", reg_index, DUMP_REGS);
        assert (mem_index == DUMP_MEMS)
            else report_value_error("o_mem_send count", mem_index, DUMP_MEMS);
        @(posedge i_clock);
        #1;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Processor model and monitors
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge i_clock) begin
        #1;
        i_pc  = base;
        i_reg = base + reg_index;
        i_mem = base + 32'h1000 + mem_index;
    end

    always @(negedge i_clock) begin
        if (!i_reset) begin
            if (o_loading) begin
                load_instr_q.push_back(o_instruction);
                load_addr_q.push_back(o_address);
            end
            if (o_reg_send) reg_index = reg_index + 1;
            if (o_mem_send) mem_index = mem_index + 1;
            if (o_step) step_count = step_count + 1;
        end
    end

    initial begin : tx_monitor
        logic [BYTE_WIDTH-1:0] data;
        int                    i;
        forever begin
            @(negedge i_clock);
            if (!i_reset && o_tx === 1'b0) begin
                repeat (BIT_CLOCKS / 2) @(negedge i_clock);
                for (i = 0; i < BYTE_WIDTH; i++) begin
                    repeat (BIT_CLOCKS) @(negedge i_clock);
                    data[i] = o_tx;
                end
                repeat (BIT_CLOCKS) @(negedge i_clock);
                assert (o_tx === 1'b1) else report_failure("stop bit on o_tx is low");
                tx_q.push_back(data);
            end
        end
    end

    always @(posedge i_clock) begin
        cycle_count = cycle_count + 1;
        assert (cycle_count <= cycle_limit)
            else report_failure("run did not finish within its cycle limit");
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int                    fd;
        int                    n;
        int                    idx;
        int                    b;
        int                    byte_total;
        int                    load_total;
        int                    step_total;
        int                    loads_before;
        int                    steps_before;
        string                 line;
        logic [BYTE_WIDTH-1:0] cmd;
        logic [WORD_WIDTH-1:0] value;
        logic [WORD_WIDTH-1:0] expected;

        i_reset     = 1'b1;
        i_rx        = 1'b1;
        i_finish    = 1'b0;
        i_pc        = '0;
        i_reg       = '0;
        i_mem       = '0;
        base        = '0;
        reg_index   = 0;
        mem_index   = 0;
        step_count  = 0;
        cycle_count = 0;
        cycle_limit = 32'h7fff_ffff;
        byte_total  = 0;
        load_total  = 0;
        step_total  = 0;

        fd = $fopen("sim/debug_stim.txt", "r");
        if (fd == 0) report_failure("could not open sim/debug_stim.txt");
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%c %h %h", cmd, value, expected);
            if (n == 3 && cmd != "#") begin
                cmd_q.push_back(cmd);
                value_q.push_back(value);
                expected_q.push_back(expected);
                if (cmd == "L") byte_total += BYTES_PER_WORD;
                if (cmd == "M" || cmd == "X" || cmd == "S") byte_total += 1;
                if (cmd == "S" || cmd == "F") begin
                    byte_total += BYTES_PER_WORD * (1 + DUMP_REGS + DUMP_MEMS);
                end
                if (cmd == "L" && value != '0) load_total += 1;
                if (cmd == "S") step_total += 1;
            end
        end
        $fclose(fd);
        cycle_limit = byte_total * 10 * BIT_CLOCKS + 4000;

        repeat (2) @(posedge i_clock);
        #1;
        i_reset = 1'b0;

        for (idx = 0; idx < cmd_q.size(); idx++) begin
            value    = value_q[idx];
            expected = expected_q[idx];
            case (cmd_q[idx])
                "L": begin
                    loads_before = load_instr_q.size();
                    for (b = 0; b < BYTES_PER_WORD; b++) send_byte(value[8*b +: 8]);
                    if (value != '0) begin
                        assert (load_instr_q.size() == loads_before + 1)
                            else report_failure("no single load strobe for a nonzero word");
                        assert (load_instr_q[loads_before] == value)
                            else report_value_error("o_instruction",
                                                    load_instr_q[loads_before], value);
                        assert (load_addr_q[loads_before] == expected)
                            else report_value_error("o_address",
                                                    load_addr_q[loads_before], expected);
                    end else begin
                        assert (load_instr_q.size() == loads_before)
                            else report_failure("zero word gave a load strobe");
                    end
                end
                "M", "X": begin
                    send_byte(value[BYTE_WIDTH-1:0]);
                end
                "S": begin
                    base         = value;
                    reg_index    = 0;
                    mem_index    = 0;
                    steps_before = step_count;
                    send_byte(CMD_STEP);
                    assert (step_count == steps_before + 1)
                        else report_value_error("o_step count", step_count, steps_before + 1);
                    check_dump(value);
                end
                "F": begin
                    base         = value;
                    reg_index    = 0;
                    mem_index    = 0;
                    steps_before = step_count;
                    i_finish     = 1'b1;
                    @(posedge i_clock);
                    #1;
                    i_finish = 1'b0;
                    check_dump(value);
                    assert (step_count == steps_before)
                        else report_failure("finish dump gave a step pulse");
                end
                default: report_failure("unknown command in stim file");
            endcase
            // Mode level after every command but a load
            if (cmd_q[idx] != "L") begin
                assert ({o_start, o_run} == expected[1:0])
                    else report_value_error("{o_start, o_run}", {30'd0, o_start, o_run},
                                            expected);
            end
        end

        // Nothing may appear outside the commanded loads, steps and dumps
        assert (load_instr_q.size() == load_total)
            else report_value_error("o_loading count", load_instr_q.size(), load_total);
        assert (step_count == step_total)
            else report_value_error("o_step count", step_count, step_total);
        assert (tx_q.size() == 0)
            else report_failure("o_tx sent bytes beyond the expected dumps");

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== hw/debug_unit.sv ====
module debug_unit import debug_pkg::*; (
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  logic                  i_rx,
    input  logic                  i_finish,
    input  logic [WORD_WIDTH-1:0] i_pc,
    input  logic [WORD_WIDTH-1:0] i_reg,
    input  logic [WORD_WIDTH-1:0] i_mem,
    output logic                  o_tx,
    output logic [WORD_WIDTH-1:0] o_instruction,
    output logic [WORD_WIDTH-1:0] o_address,
    output logic                  o_loading,
    output logic                  o_start,
    output logic                  o_step,
    output logic                  o_run,
    output logic                  o_reg_send,
    output logic                  o_mem_send
);

    logic [BYTE_WIDTH-1:0] rx_byte;
    logic                  rx_valid;
    logic                  load_active;
    logic                  load_end;
    logic                  dump_go;
    logic                  dump_done;
    logic                  tx_start;
    logic [BYTE_WIDTH-1:0] tx_byte;
    logic                  tx_busy;

    ////////////////////////////////////////////////////////////////////////////
    // Serial link
    ////////////////////////////////////////////////////////////////////////////

    uart_rx u_uart_rx (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_rx    (i_rx),
        .o_byte  (rx_byte),
        .o_valid (rx_valid)
    );

    uart_tx u_uart_tx (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_start (tx_start),
        .i_byte  (tx_byte),
        .o_tx    (o_tx),
        .o_busy  (tx_busy)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Loader, dump and control
    ////////////////////////////////////////////////////////////////////////////

    program_loader u_program_loader (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_active      (load_active),
        .i_byte        (rx_byte),
        .i_valid       (rx_valid),
        .o_loading     (o_loading),
        .o_instruction (o_instruction),
        .o_address     (o_address),
        .o_end         (load_end)
    );

    dump_serializer u_dump_serializer (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_go       (dump_go),
        .i_pc       (i_pc),
        .i_reg      (i_reg),
        .i_mem      (i_mem),
        .i_tx_busy  (tx_busy),
        .o_tx_start (tx_start),
        .o_tx_byte  (tx_byte),
        .o_reg_send (o_reg_send),
        .o_mem_send (o_mem_send),
        .o_done     (dump_done)
    );

    debug_control u_debug_control (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_byte        (rx_byte),
        .i_valid       (rx_valid),
        .i_load_end    (load_end),
        .i_dump_done   (dump_done),
        .i_finish      (i_finish),
        .o_load_active (load_active),
        .o_start       (o_start),
        .o_step        (o_step),
        .o_run         (o_run),
        .o_dump_go     (dump_go)
    );

endmodule

// ==== hw/debug_control.sv ====
module debug_control import debug_pkg::*; (
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  logic [BYTE_WIDTH-1:0] i_byte,
    input  logic                  i_valid,
    input  logic                  i_load_end,
    input  logic                  i_dump_done,
    input  logic                  i_finish,
    output logic                  o_load_active,
    output logic                  o_start,
    output logic                  o_step,
    output logic                  o_run,
    output logic                  o_dump_go
);

    debug_state_t state;

    assign o_load_active = (state == LOAD);
    assign o_start       = (state == STEP_WAIT) || (state == DUMP) || (state == RUN);
    assign o_run         = (state == RUN);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state     <= LOAD;
            o_step    <= 1'b0;
            o_dump_go <= 1'b0;
        end else begin
            o_step    <= 1'b0;
            o_dump_go <= 1'b0;
            case (state)
                LOAD: begin
                    if (i_load_end) begin
                        state <= MODE;
                    end
                end
                MODE: begin
                    // Other mode values are dropped
                    if (i_valid && i_byte == CMD_DEBUG) begin
                        state <= STEP_WAIT;
                    end else if (i_valid && i_byte == CMD_RUN) begin
                        state <= RUN;
                    end
                end
                STEP_WAIT: begin
                    if (i_finish) begin
                        state     <= FINAL_DUMP;
                        o_dump_go <= 1'b1;
                    end else if (i_valid && i_byte == CMD_STEP) begin
                        state     <= DUMP;
                        o_step    <= 1'b1;
                        o_dump_go <= 1'b1;
                    end
                end
                DUMP: begin
                    if (i_dump_done) begin
                        state <= STEP_WAIT;
                    end
                end
                RUN: begin
                    if (i_finish) begin
                        state     <= FINAL_DUMP;
                        o_dump_go <= 1'b1;
                    end
                end
                FINAL_DUMP: begin
                    if (i_dump_done) begin
                        state <= LOAD;
                    end
                end
                default: begin
                    state <= LOAD;
                end
            endcase
        end
    end

endmodule

// ==== hw/dump_serializer.sv ====
module dump_serializer import debug_pkg::*; (
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  logic                  i_go,
    input  logic [WORD_WIDTH-1:0] i_pc,
    input  logic [WORD_WIDTH-1:0] i_reg,
    input  logic [WORD_WIDTH-1:0] i_mem,
    input  logic                  i_tx_busy,
    output logic                  o_tx_start,
    output logic [BYTE_WIDTH-1:0] o_tx_byte,
    output logic                  o_reg_send,
    output logic                  o_mem_send,
    output logic                  o_done
);

    logic                                     active;
    // 0 is the PC, 1 the registers, 2 the memory
    logic [1:0]                               section;
    logic [$clog2(DUMP_REGS + DUMP_MEMS)-1:0] word_count;
    logic [1:0]                               byte_count;
    logic [WORD_WIDTH-1:0]                    shift;
    logic [WORD_WIDTH-1:0]                    word_in;
    logic                                     last_word;
    logic                                     send_now;

    // Start pulse is still visible to the transmitter before busy rises
    assign send_now = active && !i_tx_busy && !o_tx_start;

    always_comb begin
        case (section)
            2'd0: begin
                word_in   = i_pc;
                last_word = 1'b1;
            end
            2'd1: begin
                word_in   = i_reg;
                last_word = (word_count == DUMP_REGS - 1);
            end
            default: begin
                word_in   = i_mem;
                last_word = (word_count == DUMP_MEMS - 1);
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Byte path
    ////////////////////////////////////////////////////////////////////////////

    // Whole word is captured with its first byte
    always_ff @(posedge i_clock) begin
        if (send_now) begin
            if (byte_count == 2'd0) begin
                o_tx_byte <= word_in[BYTE_WIDTH-1:0];
                shift     <= word_in >> BYTE_WIDTH;
            end else begin
                o_tx_byte <= shift[BYTE_WIDTH-1:0];
                shift     <= shift >> BYTE_WIDTH;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Sequencing
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            active     <= 1'b0;
            section    <= '0;
            word_count <= '0;
            byte_count <= '0;
            o_tx_start <= 1'b0;
            o_reg_send <= 1'b0;
            o_mem_send <= 1'b0;
            o_done     <= 1'b0;
        end else begin
            o_tx_start <= 1'b0;
            o_reg_send <= 1'b0;
            o_mem_send <= 1'b0;
            o_done     <= 1'b0;
            if (i_go) begin
                active     <= 1'b1;
                section    <= '0;
                word_count <= '0;
                byte_count <= '0;
            end else if (send_now) begin
                o_tx_start <= 1'b1;
                byte_count <= byte_count + 1'b1;
                if (byte_count == BYTES_PER_WORD - 1) begin
                    // Processor moves to the next index on these
                    o_reg_send <= (section == 2'd1);
                    o_mem_send <= (section == 2'd2);
                    if (last_word) begin
                        word_count <= '0;
                        section    <= section + 1'b1;
                        if (section == 2'd2) begin
                            active <= 1'b0;
                            o_done <= 1'b1;
                        end
                    end else begin
                        word_count <= word_count + 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== hw/program_loader.sv ====
module program_loader import debug_pkg::*; (
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  logic                  i_active,
    input  logic [BYTE_WIDTH-1:0] i_byte,
    input  logic                  i_valid,
    output logic                  o_loading,
    output logic [WORD_WIDTH-1:0] o_instruction,
    output logic [WORD_WIDTH-1:0] o_address,
    output logic                  o_end
);

    logic [1:0]            byte_count;
    logic [WORD_WIDTH-1:0] word;
    logic [WORD_WIDTH-1:0] next_word;
    logic [WORD_WIDTH-1:0] address;

    // New byte enters at the top, so the first one ends up in bits 7:0
    assign next_word = {i_byte, word[WORD_WIDTH-1:BYTE_WIDTH]};

    assign o_instruction = o_loading ? word : '0;
    assign o_address     = o_loading ? address : '0;

    always_ff @(posedge i_clock) begin
        if (i_active && i_valid) begin
            word <= next_word;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            byte_count <= '0;
            address    <= '0;
            o_loading  <= 1'b0;
            o_end      <= 1'b0;
        end else begin
            o_loading <= 1'b0;
            o_end     <= 1'b0;
            if (o_loading) begin
                address <= address + 1'b1;
            end
            if (!i_active) begin
                byte_count <= '0;
            end else if (i_valid) begin
                byte_count <= byte_count + 1'b1;
                if (byte_count == BYTES_PER_WORD - 1) begin
                    // Zero word terminates the program
                    if (next_word == '0) begin
                        o_end      <= 1'b1;
                        address    <= '0;
                        byte_count <= '0;
                    end else begin
                        o_loading <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== hw/uart_tx.sv ====
module uart_tx import debug_pkg::*; (
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  logic                  i_start,
    input  logic [BYTE_WIDTH-1:0] i_byte,
    output logic                  o_tx,
    output logic                  o_busy
);

    logic [BYTE_WIDTH+1:0]         frame;
    logic [$clog2(BIT_CLOCKS)-1:0] clk_count;
    logic [3:0]                    bit_count;

    // Bit 0 of the frame is always on the line
    assign o_tx = frame[0];

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            frame     <= '1;
            o_busy    <= 1'b0;
            clk_count <= '0;
            bit_count <= '0;
        end else if (!o_busy) begin
            clk_count <= '0;
            bit_count <= '0;
            if (i_start) begin
                // Stop, data, start
                frame  <= {1'b1, i_byte, 1'b0};
                o_busy <= 1'b1;
            end
        end else if (clk_count == BIT_CLOCKS - 1) begin
            clk_count <= '0;
            frame     <= {1'b1, frame[BYTE_WIDTH+1:1]};
            if (bit_count == BYTE_WIDTH + 1) begin
                o_busy <= 1'b0;
            end else begin
                bit_count <= bit_count + 1'b1;
            end
        end else begin
            clk_count <= clk_count + 1'b1;
        end
    end

endmodule

// ==== hw/uart_rx.sv ====
module uart_rx import debug_pkg::*; (
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  logic                  i_rx,
    output logic [BYTE_WIDTH-1:0] o_byte,
    output logic                  o_valid
);

    logic [1:0]                    rx_sync;
    logic                          rx_line;
    logic                          busy;
    logic [$clog2(BIT_CLOCKS)-1:0] clk_count;
    logic [3:0]                    bit_index;
    logic [BYTE_WIDTH-1:0]         shift;
    logic                          sample;

    assign rx_line = rx_sync[1];
    assign o_byte  = shift;
    assign sample  = busy && (bit_index != 4'd0) && (clk_count == BIT_CLOCKS - 1);

    // Line idles high
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            rx_sync <= 2'b11;
        end else begin
            rx_sync <= {rx_sync[0], i_rx};
        end
    end

    // Bit index 0 is the start bit, BYTE_WIDTH + 1 the stop bit
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            busy      <= 1'b0;
            clk_count <= '0;
            bit_index <= '0;
            o_valid   <= 1'b0;
        end else begin
            o_valid <= 1'b0;
            if (!busy) begin
                clk_count <= '0;
                bit_index <= '0;
                if (!rx_line) begin
                    busy <= 1'b1;
                end
            end else if (bit_index == 4'd0) begin
                if (clk_count == BIT_CLOCKS / 2 - 1) begin
                    clk_count <= '0;
                    bit_index <= 4'd1;
                    // Line back high, only a glitch
                    if (rx_line) begin
                        busy <= 1'b0;
                    end
                end else begin
                    clk_count <= clk_count + 1'b1;
                end
            end else if (sample) begin
                clk_count <= '0;
                bit_index <= bit_index + 1'b1;
                if (bit_index == BYTE_WIDTH + 1) begin
                    busy    <= 1'b0;
                    o_valid <= rx_line;
                end
            end else begin
                clk_count <= clk_count + 1'b1;
            end
        end
    end

    // LSB arrives first
    always_ff @(posedge i_clock) begin
        if (sample && bit_index <= BYTE_WIDTH) begin
            shift <= {rx_line, shift[BYTE_WIDTH-1:1]};
        end
    end

endmodule

// ==== hw/debug_pkg.sv ====
package debug_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and serial timing
    ////////////////////////////////////////////////////////////////////////////

    localparam int WORD_WIDTH     = 32;
    localparam int BYTE_WIDTH     = 8;
    localparam int BYTES_PER_WORD = 4;

    // Clocks per serial bit
    localparam int BIT_CLOCKS     = 16;

    // Words per dump section, after the PC
    localparam int DUMP_REGS      = 32;
    localparam int DUMP_MEMS      = 32;

    ////////////////////////////////////////////////////////////////////////////
    // Controller states and command bytes
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        LOAD,
        MODE,
        STEP_WAIT,
        DUMP,
        RUN,
        FINAL_DUMP
    } debug_state_t;

    typedef enum logic [7:0] {
        CMD_RUN   = 8'h00,
        CMD_STEP  = 8'hAA,
        CMD_DEBUG = 8'hFF
    } debug_cmd_t;

endpackage
